//--- verilog/rtefi_pkg.sv
// Shared widths, frame offsets and power-up tables for the UDP receive core
// Offsets assume an untagged Ethernet II frame with a 20-byte IPv4 header
package rtefi_pkg;

	// Packet buffer address width, one frame deep at 2 KiB
	localparam int paw = 11;

	typedef logic [7:0] byte_t;
	typedef logic [paw-1:0] pbuf_addr_t;
	// Bit 8 flags the first byte of a frame
	typedef logic [8:0] pbuf_word_t;
	typedef logic [10:0] frame_len_t;
	typedef logic [3:0] cfg_addr_t;
	typedef logic [2:0] udp_sel_t;
	typedef logic [7:0] status_t;

	// Status vector bit positions
	localparam int st_mac_ok = 0;
	localparam int st_ip_ok = 1;
	localparam int st_udp_ok = 2;
	localparam int st_err = 3;
	localparam int st_len_bad = 4;
	// Lowest bit of the three-bit udp_sel field
	localparam int st_sel_lo = 5;

	// Legal frame length in bytes, without CRC
	localparam int min_len = 42;
	localparam int max_len = 1514;

	// Byte offsets inside the frame
	localparam int off_mac = 0;
	localparam int off_etype = 12;
	localparam int off_proto = 23;
	localparam int off_dip = 30;
	localparam int off_dport = 36;

	localparam logic [15:0] etype_ipv4 = 16'h0800;
	localparam byte_t proto_udp = 8'd17;

	// Port table size and start of the IP bytes in the MAC/IP table
	localparam int n_ports = 8;
	localparam int tbl_ip_base = 6;

	// Power-up table contents
	localparam logic [47:0] mac_default = 48'h12555500012d;
	localparam logic [31:0] ip_default = {8'd192, 8'd168, 8'd7, 8'd4};
	localparam logic [0:n_ports-1][15:0] udp_port_default = {
		16'd7, 16'd801, 16'd802, 16'd803, 16'd0, 16'd0, 16'd0, 16'd0
	};

	typedef enum logic [1:0] {idle, active, drain, report} scan_state_t;

endpackage

//--- verilog/addr_config_mem.sv
// Address and port tables written from the rx_clk configuration port
// Contents come back to defaults only through initial values, not on reset
`timescale 1ns/1ps

module addr_config_mem (
	input logic rx_clk,
	input rtefi_pkg::cfg_addr_t config_a,
	input rtefi_pkg::byte_t config_d,
	input logic config_s,
	input logic config_p,
	input rtefi_pkg::cfg_addr_t ip_a,
	input rtefi_pkg::cfg_addr_t pno_a,
	output rtefi_pkg::byte_t ip_d,
	output rtefi_pkg::byte_t pno_d
);
	import rtefi_pkg::*;

	// Six MAC bytes then four IP bytes, rest unused
	byte_t ip_mem [0:(1 << $bits(cfg_addr_t))-1];
	// Eight ports, high byte at the even address
	byte_t pno_mem [0:(1 << $bits(cfg_addr_t))-1];

	initial begin
		for (int i = 0; i < (1 << $bits(cfg_addr_t)); i++) begin
			ip_mem[i] = '0;
		end
		for (int i = 0; i < 6; i++) begin
			ip_mem[i] = mac_default[47-8*i -: 8];
		end
		for (int i = 0; i < 4; i++) begin
			ip_mem[tbl_ip_base+i] = ip_default[31-8*i -: 8];
		end
		// Port numbers split big endian like on the wire
		for (int k = 0; k < n_ports; k++) begin
			pno_mem[2*k] = udp_port_default[k][15:8];
			pno_mem[2*k+1] = udp_port_default[k][7:0];
		end
	end

	// Table writes share one address and data bus
	always @(posedge rx_clk) begin
		if (config_s)
			ip_mem[config_a] <= config_d;
		if (config_p)
			pno_mem[config_a] <= config_d;
	end

	// Registered reads, so data arrives one cycle after the address
	always_ff @(posedge rx_clk) begin
		ip_d <= ip_mem[ip_a];
		pno_d <= pno_mem[pno_a];
	end

	// Only one table may take the shared write bus at a time
	a_one_table: assert property (@(posedge rx_clk) !(config_s && config_p))
		else $error("config_s and config_p high together");

endmodule

//--- verilog/rx_scanner.sv
// Frame scanner for preamble-stripped GMII bytes and no CRC check
// Frames starting while a report is pending are skipped whole
`timescale 1ns/1ps

module rx_scanner (
	input logic rx_clk,
	input logic rst_n,
	input rtefi_pkg::byte_t eth_d,
	input logic eth_s,
	input logic eth_e,
	input logic enable_rx,
	input rtefi_pkg::byte_t ip_d,
	input rtefi_pkg::byte_t pno_d,
	output rtefi_pkg::cfg_addr_t ip_a,
	output rtefi_pkg::cfg_addr_t pno_a,
	output rtefi_pkg::byte_t sdata,
	output logic sdata_s,
	output logic sdata_l,
	output rtefi_pkg::frame_len_t pack_len,
	output rtefi_pkg::status_t status_vec,
	output logic status_valid
);
	import rtefi_pkg::*;

	scan_state_t state;
	// Index of the byte now in eth_d while active
	frame_len_t cnt;
	frame_len_t cidx;
	// Index of the byte that comes next, for the table lookahead
	frame_len_t la;
	logic eth_s_d;
	logic start, fresh, take, frame_end;
	logic tbl_eq, len_bad;
	logic mac_run, ip_run, proto_run, err_seen, port_hit;
	logic [n_ports-1:0] hi_eq, hi_hit, port_match;
	udp_sel_t sel, sel_next;
	status_t status_next;
	// Local copy of the port table, refilled over bytes 0 to 15
	byte_t port_tbl [0:2*n_ports-1];

	assign start = eth_s & ~eth_s_d;
	assign fresh = (state == idle);
	// A byte is taken on a fresh start or inside an active frame
	assign take = fresh ? (start & enable_rx) : ((state == active) & eth_s);
	assign frame_end = (state == active) & ~eth_s;
	assign cidx = fresh ? '0 : cnt;
	assign la = take ? cidx + 1'b1 : '0;

	// Table addresses lead the data by one byte
	always_comb begin
		ip_a = '0;
		if (la < off_mac + 6)
			ip_a = la[3:0];
		else if (la >= off_dip && la < off_dip + 4)
			ip_a = cfg_addr_t'(la - off_dip + tbl_ip_base);
	end
	assign pno_a = (la < 2 * n_ports) ? la[3:0] : '0;

	assign tbl_eq = (eth_d == ip_d);
	assign len_bad = (cnt < min_len) || (cnt > max_len);

	// Port match over two bytes, lowest index wins
	always_comb begin
		for (int k = 0; k < n_ports; k++) begin
			hi_eq[k] = (eth_d == port_tbl[2*k]);
			port_match[k] = hi_hit[k] & (eth_d == port_tbl[2*k+1]);
		end
		sel_next = '0;
		for (int k = n_ports - 1; k >= 0; k--) begin
			if (port_match[k])
				sel_next = udp_sel_t'(k);
		end
	end

	// Bits only count once their bytes have arrived
	always_comb begin
		status_next = '0;
		status_next[st_mac_ok] = mac_run & (cnt > off_mac + 5);
		status_next[st_ip_ok] = ip_run & (cnt > off_dip + 3);
		status_next[st_udp_ok] = port_hit;
		status_next[st_err] = err_seen;
		status_next[st_len_bad] = len_bad;
		status_next[st_sel_lo +: $bits(udp_sel_t)] = port_hit ? sel : '0;
	end

	// Control FSM with one byte of data delay
	always_ff @(posedge rx_clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= idle;
			cnt <= '0;
			eth_s_d <= 1'b0;
			sdata_s <= 1'b0;
			status_valid <= 1'b0;
		end else begin
			eth_s_d <= eth_s;
			sdata_s <= take;
			status_valid <= (state == report);
			case (state)
				idle: begin
					if (start && enable_rx) begin
						state <= active;
						cnt <= frame_len_t'(1);
					end
				end
				active: begin
					// Count saturates so oversize frames stay flagged
					if (eth_s) begin
						if (cnt != '1)
							cnt <= cnt + 1'b1;
					end else begin
						state <= drain;
					end
				end
				drain: state <= report;
				report: state <= idle;
				default: state <= idle;
			endcase
		end
	end

	// Per-frame match flags and data path
	always_ff @(posedge rx_clk) begin
		sdata <= eth_d;
		if (take) begin
			if (cidx < 2 * n_ports)
				port_tbl[cidx[3:0]] <= pno_d;
			if (cidx < off_mac + 6)
				mac_run <= (fresh | mac_run) & tbl_eq;
			if (fresh) begin
				ip_run <= 1'b1;
				err_seen <= eth_e;
				port_hit <= 1'b0;
			end else begin
				err_seen <= err_seen | eth_e;
				if (cidx == off_etype)
					ip_run <= ip_run & (eth_d == etype_ipv4[15:8]);
				if (cidx == off_etype + 1)
					ip_run <= ip_run & (eth_d == etype_ipv4[7:0]);
				if (cidx >= off_dip && cidx < off_dip + 4)
					ip_run <= ip_run & tbl_eq;
				if (cidx == off_proto)
					proto_run <= (eth_d == proto_udp);
				if (cidx == off_dport)
					hi_hit <= hi_eq;
				// Protocol byte comes earlier, so it folds in here
				if (cidx == off_dport + 1) begin
					port_hit <= proto_run & (|port_match);
					sel <= sel_next;
				end
			end
		end
		if (frame_end) begin
			pack_len <= cnt;
			status_vec <= status_next;
		end
	end

	// Last byte is known once the input strobe drops
	assign sdata_l = sdata_s & ~eth_s;

	a_valid_pulse: assert property (@(posedge rx_clk) disable iff (!rst_n)
		status_valid |=> !status_valid)
		else $error("status_valid longer than one cycle");

	a_idle_quiet: assert property (@(posedge rx_clk) disable iff (!rst_n)
		(state == idle) |-> !sdata_s)
		else $error("sdata_s high while scanner idle");

endmodule

//--- verilog/pbuf_writer.sv
// Packet buffer writer with commit or rewind at each report
// Pointer wraps over the buffer and one frame deep is assumed
`timescale 1ns/1ps

module pbuf_writer (
	input logic rx_clk,
	input logic rst_n,
	input rtefi_pkg::byte_t data_in,
	input logic data_s,
	input logic data_f,
	input rtefi_pkg::status_t status_vec,
	input logic status_valid,
	output rtefi_pkg::pbuf_addr_t mem_a,
	output rtefi_pkg::pbuf_word_t mem_d,
	output logic commit_stb,
	output rtefi_pkg::pbuf_addr_t commit_ptr
);
	import rtefi_pkg::*;

	// Next address to write
	pbuf_addr_t wr_ptr;
	logic in_frame;
	logic first;
	logic accept;

	// First byte is a strobe with no frame already open
	assign first = data_s & ~in_frame;

	// Keep only frames that pass every check
	assign accept = status_vec[st_mac_ok] & status_vec[st_ip_ok] &
		status_vec[st_udp_ok] & ~status_vec[st_err] & ~status_vec[st_len_bad];

	// Memory writes every cycle
	// Idle cycles just scribble on the next free slot
	assign mem_a = wr_ptr;
	assign mem_d = {first, data_in};

	always_ff @(posedge rx_clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			in_frame <= 1'b0;
			commit_ptr <= '0;
			commit_stb <= 1'b0;
		end else begin
			commit_stb <= status_valid & accept;
			if (data_s) begin
				wr_ptr <= wr_ptr + 1'b1;
				// Last byte closes the frame
				in_frame <= ~data_f;
			end
			// Report never overlaps data, so these never collide
			if (status_valid) begin
				if (accept)
					commit_ptr <= wr_ptr;
				else
					wr_ptr <= commit_ptr;
			end
		end
	end

	// Commit only one cycle behind a report and only past written frame data
	a_commit_after_report: assert property (@(posedge rx_clk) disable iff (!rst_n)
		commit_stb |-> $past(status_valid) && (commit_ptr != $past(commit_ptr)))
		else $error("commit_stb without status_valid or without frame data");

	// Scanner must finish the data before it reports
	a_report_after_data: assert property (@(posedge rx_clk) disable iff (!rst_n)
		status_valid |-> !data_s)
		else $error("status_valid during frame data");

endmodule

//--- verilog/packet_buffer.sv
// Simple dual-port frame memory on rx_clk with no write enable
// Power-up contents are zero from initial values only
`timescale 1ns/1ps

module packet_buffer (
	input logic rx_clk,
	input rtefi_pkg::pbuf_addr_t wr_a,
	input rtefi_pkg::pbuf_word_t wr_d,
	input rtefi_pkg::pbuf_addr_t rd_a,
	output rtefi_pkg::pbuf_word_t rd_d
);
	import rtefi_pkg::*;

	// One word per byte plus the start-of-frame bit
	pbuf_word_t mem [0:(1 << paw)-1];

	initial begin
		for (int i = 0; i < (1 << paw); i++) begin
			mem[i] = '0;
		end
	end

	// Writer drives a valid address every cycle
	always @(posedge rx_clk) begin
		mem[wr_a] <= wr_d;
	end

	// Read through a register
	// Data lands one cycle after the address
	always_ff @(posedge rx_clk) begin
		rd_d <= mem[rd_a];
	end

endmodule

//--- verilog/rtefi_rx_center.sv
// Receive side of the UDP responder on one rx_clk domain
// GMII input with preamble removed and configuration synchronous to rx_clk
`timescale 1ns/1ps

module rtefi_rx_center (
	input logic rx_clk,
	input logic rst_n,
	// GMII receive
	input rtefi_pkg::byte_t rxd,
	input logic rx_dv,
	input logic rx_er,
	input logic enable_rx,
	// Table writes
	input rtefi_pkg::cfg_addr_t config_a,
	input rtefi_pkg::byte_t config_d,
	input logic config_s,
	input logic config_p,
	// Buffer read side
	input rtefi_pkg::pbuf_addr_t rd_a,
	// Per-frame report
	output logic status_valid,
	output rtefi_pkg::status_t status_vec,
	output rtefi_pkg::frame_len_t pack_len,
	output logic commit_stb,
	output rtefi_pkg::pbuf_addr_t commit_ptr,
	output rtefi_pkg::pbuf_word_t rd_d
);
	import rtefi_pkg::*;

	// Registered GMII input
	byte_t eth_d;
	logic eth_s;
	logic eth_e;
	// Table lookup from the scanner
	cfg_addr_t ip_a;
	cfg_addr_t pno_a;
	byte_t ip_d;
	byte_t pno_d;
	// Scanner byte stream
	byte_t sdata;
	logic sdata_s;
	logic sdata_l;
	// Buffer write port
	pbuf_addr_t mem_a;
	pbuf_word_t mem_d;

	// Input flops kept free of logic so they can sit at the pads
	always_ff @(posedge rx_clk or negedge rst_n) begin
		if (!rst_n) begin
			eth_s <= 1'b0;
			eth_e <= 1'b0;
		end else begin
			eth_s <= rx_dv;
			eth_e <= rx_er;
		end
	end

	always_ff @(posedge rx_clk) begin
		eth_d <= rxd;
	end

	addr_config_mem cfg_i (
		.rx_clk(rx_clk), .config_a(config_a), .config_d(config_d),
		.config_s(config_s), .config_p(config_p),
		.ip_a(ip_a), .pno_a(pno_a), .ip_d(ip_d), .pno_d(pno_d)
	);

	rx_scanner scan_i (
		.rx_clk(rx_clk), .rst_n(rst_n),
		.eth_d(eth_d), .eth_s(eth_s), .eth_e(eth_e), .enable_rx(enable_rx),
		.ip_d(ip_d), .pno_d(pno_d), .ip_a(ip_a), .pno_a(pno_a),
		.sdata(sdata), .sdata_s(sdata_s), .sdata_l(sdata_l),
		.pack_len(pack_len), .status_vec(status_vec), .status_valid(status_valid)
	);

	pbuf_writer wr_i (
		.rx_clk(rx_clk), .rst_n(rst_n),
		.data_in(sdata), .data_s(sdata_s), .data_f(sdata_l),
		.status_vec(status_vec), .status_valid(status_valid),
		.mem_a(mem_a), .mem_d(mem_d),
		.commit_stb(commit_stb), .commit_ptr(commit_ptr)
	);

	packet_buffer buf_i (
		.rx_clk(rx_clk), .wr_a(mem_a), .wr_d(mem_d), .rd_a(rd_a), .rd_d(rd_d)
	);

endmodule

//--- sim/rtefi_rx_tb.sv
// Data-driven testbench reading sim/rx_stim.txt relative to the project root
// One frame in flight at a time and each report awaited for at most 200 cycles
`timescale 1ns/1ps

module rtefi_rx_tb;
	import rtefi_pkg::*;

	logic rx_clk;
	logic rst_n;
	byte_t rxd;
	logic rx_dv;
	logic rx_er;
	logic enable_rx;
	cfg_addr_t config_a;
	byte_t config_d;
	logic config_s;
	logic config_p;
	pbuf_addr_t rd_a;
	logic status_valid;
	status_t status_vec;
	frame_len_t pack_len;
	logic commit_stb;
	pbuf_addr_t commit_ptr;
	pbuf_word_t rd_d;

	// Current record and its expectations
	byte_t frame [0:2047];
	int fd, code, len, en, acc, err_idx, tbl, addr, data, b;
	logic [7:0] exp_status;
	logic [31:0] lfsr;
	// Expected first free buffer address
	pbuf_addr_t ptr_model;
	logic [63:0] tag;
	logic [8*128-1:0] rest;

	rtefi_rx_center dut_i (
		.rx_clk(rx_clk), .rst_n(rst_n), .rxd(rxd), .rx_dv(rx_dv), .rx_er(rx_er),
		.enable_rx(enable_rx), .config_a(config_a), .config_d(config_d),
		.config_s(config_s), .config_p(config_p), .rd_a(rd_a),
		.status_valid(status_valid), .status_vec(status_vec), .pack_len(pack_len),
		.commit_stb(commit_stb), .commit_ptr(commit_ptr), .rd_d(rd_d)
	);

	always #4 rx_clk = ~rx_clk;

	task check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("[FAIL] %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
			$display("TEST RESULT: FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	task abort_run(input string why);
		$display("%s", why);
		$display("TEST RESULT: FAIL");
		$fatal(1, "run aborted");
	endtask

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task take_bits(input int n, output int v);
		v = 0;
		for (int i = 0; i < n; i++) begin
			v = (v << 1) | lfsr[0];
			lfsr = lfsr_next(lfsr);
		end
	endtask

	// Idle gap of 4 to 11 cycles
	task idle_gap;
		int n;
		take_bits(3, n);
		repeat (4 + n) @(negedge rx_clk);
	endtask

	task config_write(input int t, input int a, input int d);
		@(negedge rx_clk);
		config_a = a;
		config_d = d;
		config_s = (t == 0);
		config_p = (t == 1);
		@(negedge rx_clk);
		config_s = 1'b0;
		config_p = 1'b0;
	endtask

	task send_frame;
		for (int i = 0; i < len; i++) begin
			@(negedge rx_clk);
			rx_dv = 1'b1;
			rxd = frame[i];
			rx_er = (i == err_idx);
		end
		@(negedge rx_clk);
		rx_dv = 1'b0;
		rx_er = 1'b0;
		rxd = '0;
	endtask

	// Counts falling edges from the rx_dv drop until status_valid
	task wait_status(output logic got, output int n);
		got = 1'b0;
		n = 0;
		while (!got && n < 200) begin
			@(negedge rx_clk);
			n++;
			got = status_valid;
		end
	endtask

	// Bit 8 only on the first word of the frame
	task read_back(input pbuf_addr_t base);
		for (int i = 0; i < len; i++) begin
			rd_a = base + i;
			@(negedge rx_clk);
			check_val(rd_d, {(i == 0), frame[i]}, "buffer word");
		end
	endtask

	task run_frame;
		logic seen;
		int lat;
		pbuf_addr_t base;
		enable_rx = en[0];
		idle_gap();
		send_frame();
		wait_status(seen, lat);
		if (en == 0) begin
			if (seen)
				abort_run("status_valid arrived for a frame sent with enable_rx low");
			check_val(commit_ptr, ptr_model, "commit_ptr after ignored frame");
		end else if (!seen) begin
			abort_run("No status_valid arrived within 200 cycles after a frame");
		end else begin
			// Input register takes one edge, then the report comes three edges later
			check_val(lat, 1 + 3, "status_valid latency");
			check_val(status_vec, exp_status, "status_vec");
			check_val(pack_len, len, "pack_len");
			@(negedge rx_clk);
			check_val(commit_stb, acc, "commit_stb");
			base = ptr_model;
			if (acc)
				ptr_model = ptr_model + len;
			check_val(commit_ptr, ptr_model, "commit_ptr");
			if (acc)
				read_back(base);
		end
		err_idx = -1;
	endtask

	initial begin
		rx_clk = 1'b0;
		rst_n = 1'b0;
		rxd = '0;
		rx_dv = 1'b0;
		rx_er = 1'b0;
		enable_rx = 1'b1;
		config_a = '0;
		config_d = '0;
		config_s = 1'b0;
		config_p = 1'b0;
		rd_a = '0;
		lfsr = 32'h995b102f;
		ptr_model = '0;
		err_idx = -1;
		repeat (3) @(posedge rx_clk);
		@(negedge rx_clk);
		rst_n = 1'b1;
		fd = $fopen("sim/rx_stim.txt", "r");
		if (fd == 0)
			abort_run("Could not open sim/rx_stim.txt");
		code = $fscanf(fd, "%s", tag);
		while (code == 1) begin
			if (tag == "#") begin
				code = $fgets(rest, fd);
			end else if (tag == "C") begin
				if ($fscanf(fd, "%d %h %h", tbl, addr, data) != 3)
					abort_run("Malformed configuration record in stimulus file");
				config_write(tbl, addr, data);
			end else if (tag == "X") begin
				if ($fscanf(fd, "%d", err_idx) != 1)
					abort_run("Malformed error index record in stimulus file");
			end else if (tag == "F") begin
				if ($fscanf(fd, "%d %h %d %d", en, exp_status, len, acc) != 4 || len > 2048)
					abort_run("Malformed frame header in stimulus file");
				for (int i = 0; i < len; i++) begin
					if ($fscanf(fd, "%h", b) != 1)
						abort_run("Frame in stimulus file is shorter than its length");
					frame[i] = b;
				end
				run_frame();
			end else begin
				abort_run("Unknown record type in stimulus file");
			end
			code = $fscanf(fd, "%s", tag);
		end
		$fclose(fd);
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

//--- sim/rx_stim.txt
# C table(0 mac/ip, 1 port) addr(hex) data(hex) | X index of the byte sent with rx_er
# F enable status(hex) length accept, then length bytes in hex
F 1 27 44 1 12 55 55 00 01 2d 02 00 00 00 00 01 08 00 45 00 00 1e 00 00 40
00 40 11 00 00 c0 a8 07 01 c0 a8 07 04 04 00 03 21 00 0a 00 00 ab cd
F 1 26 42 0 12 55 55 00 01 2e 02 00 00 00 00 01 08 00 45 00 00 1c 00 00 40
00 40 11 00 00 c0 a8 07 01 c0 a8 07 04 04 00 03 21 00 08 00 00
F 1 25 42 0 12 55 55 00 01 2d 02 00 00 00 00 01 08 00 45 00 00 1c 00 00 40
00 40 11 00 00 c0 a8 07 01 c0 a8 07 05 04 00 03 21 00 08 00 00
F 1 03 42 0 12 55 55 00 01 2d 02 00 00 00 00 01 08 00 45 00 00 1c 00 00 40
00 40 06 00 00 c0 a8 07 01 c0 a8 07 04 04 00 03 21 00 08 00 00
F 1 03 42 0 12 55 55 00 01 2d 02 00 00 00 00 01 08 00 45 00 00 1c 00 00 40
00 40 11 00 00 c0 a8 07 01 c0 a8 07 04 04 00 03 e7 00 08 00 00
F 1 07 42 1 12 55 55 00 01 2d 02 00 00 00 00 01 08 00 45 00 00 1c 00 00 40
00 40 11 00 00 c0 a8 07 01 c0 a8 07 04 04 00 00 07 00 08 00 00
C 0 9 09
C 1 6 12
C 1 7 34
F 1 67 42 1 12 55 55 00 01 2d 02 00 00 00 00 01 08 00 45 00 00 1c 00 00 40
00 40 11 00 00 c0 a8 07 01 c0 a8 07 09 04 00 12 34 00 08 00 00
F 1 65 42 0 12 55 55 00 01 2d 02 00 00 00 00 01 08 00 45 00 00 1c 00 00 40
00 40 11 00 00 c0 a8 07 01 c0 a8 07 04 04 00 12 34 00 08 00 00
X 20
F 1 2f 42 0 12 55 55 00 01 2d 02 00 00 00 00 01 08 00 45 00 00 1c 00 00 40
00 40 11 00 00 c0 a8 07 01 c0 a8 07 09 04 00 03 21 00 08 00 00
F 1 11 30 0 12 55 55 00 01 2d 02 00 00 00 00 01 08 00 45 00 00 1c 00 00 40
00 40 11 00 00 c0 a8 07 01
F 0 00 42 0 12 55 55 00 01 2d 02 00 00 00 00 01 08 00 45 00 00 1c 00 00 40
00 40 11 00 00 c0 a8 07 01 c0 a8 07 09 04 00 03 21 00 08 00 00
F 1 27 42 1 12 55 55 00 01 2d 02 00 00 00 00 01 08 00 45 00 00 1c 00 00 40
00 40 11 00 00 c0 a8 07 01 c0 a8 07 09 04 00 03 21 00 08 00 00

//--- flist.f
verilog/rtefi_pkg.sv
verilog/addr_config_mem.sv
verilog/rx_scanner.sv
verilog/pbuf_writer.sv
verilog/packet_buffer.sv
verilog/rtefi_rx_center.sv
sim/rtefi_rx_tb.sv
